/* rtl/pool_pkg.sv */
package pool_pkg;

  localparam int LANES    = 4;   // Lanes per beat
  localparam int SAMPLE_W = 16;  // One input or output sample
  localparam int ACC_W    = 28;  // Holds a 64-beat sum of 16-bit samples
  localparam int KDIM_W   = 3;   // Kernel dimension minus one
  localparam int CNT_W    = 6;   // Beat index within a window

  // One lane sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Four lanes of one beat, lane 0 in the low bits
  typedef logic [LANES*SAMPLE_W-1:0] beat_t;

  // One lane accumulator
  typedef logic signed [ACC_W-1:0] acc_t;

  // Kernel width or height minus one
  typedef logic [KDIM_W-1:0] kdim_t;

  // Beat index within a window
  typedef logic [CNT_W-1:0] cnt_t;

  // Pooling operation, the unused fourth code behaves as max
  typedef enum logic [1:0] {
    POOL_MAX = 2'd0,
    POOL_MIN = 2'd1,
    POOL_SUM = 2'd2
  } pool_type_e;

endpackage

/* rtl/pool_window_ctrl.sv */
module pool_window_ctrl import pool_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  beat_t      in_data,
  input  kdim_t      kernel_w,
  input  kdim_t      kernel_h,
  input  pool_type_e pool_type,
  output logic       beat_valid,
  output beat_t      beat_data,
  output logic       beat_first,
  output logic       beat_last,
  output pool_type_e beat_type
);

  logic [KDIM_W:0]     dim_w;      // kernel_w + 1
  logic [KDIM_W:0]     dim_h;      // kernel_h + 1
  logic [2*KDIM_W+1:0] win_len;    // Beats per window
  cnt_t                new_last;   // Last index from current config

  cnt_t       beat_idx;            // Index of the next beat
  cnt_t       last_idx_q;          // Latched at first beat
  pool_type_e type_q;

  logic       is_first;
  cnt_t       cur_last;
  pool_type_e cur_type;
  logic       is_last;

  always_comb begin
    dim_w    = {1'b0, kernel_w} + 1'b1;
    dim_h    = {1'b0, kernel_h} + 1'b1;
    win_len  = dim_w * dim_h;
    new_last = cnt_t'(win_len - 1'b1);
  end

  // First beat takes the live config, later beats the latched one
  assign is_first = (beat_idx == '0);
  assign cur_last = is_first ? new_last : last_idx_q;
  assign cur_type = is_first ? pool_type : type_q;
  assign is_last  = (beat_idx == cur_last);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      beat_idx   <= '0;
      last_idx_q <= '0;
      type_q     <= POOL_MAX;
    end else if (in_valid) begin
      if (is_first) begin
        last_idx_q <= new_last;
        type_q     <= pool_type;
      end
      if (is_last) begin
        beat_idx <= '0;  // Wrap for next window
      end else begin
        beat_idx <= beat_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      beat_valid <= 1'b0;
      beat_first <= 1'b0;
      beat_last  <= 1'b0;
      beat_type  <= POOL_MAX;
    end else begin
      beat_valid <= in_valid;
      if (in_valid) begin
        beat_first <= is_first;
        beat_last  <= is_last;
        beat_type  <= cur_type;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      beat_data <= in_data;
    end
  end

endmodule

/* rtl/pool_accum_buf.sv */
module pool_accum_buf import pool_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              beat_valid,
  input  beat_t             beat_data,
  input  logic              beat_first,
  input  logic              beat_last,
  input  pool_type_e        beat_type,
  output logic              acc_valid,
  output acc_t [LANES-1:0]  acc_data
);

  sample_t [LANES-1:0] lane_s;     // Raw lane samples
  acc_t    [LANES-1:0] lane_ext;   // Sign-extended samples
  acc_t    [LANES-1:0] acc_q;      // Partial results
  acc_t    [LANES-1:0] acc_nxt;    // Partial result combined with beat

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_s[i]   = beat_data[i*SAMPLE_W +: SAMPLE_W];
      lane_ext[i] = acc_t'(lane_s[i]);
    end
  end

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      if (beat_first) begin
        acc_nxt[i] = lane_ext[i];  // New window starts fresh
      end else begin
        case (beat_type)
          POOL_MIN: begin
            acc_nxt[i] = (lane_ext[i] < acc_q[i]) ? lane_ext[i] : acc_q[i];
          end
          POOL_SUM: begin
            acc_nxt[i] = acc_q[i] + lane_ext[i];
          end
          default: begin  // POOL_MAX and the spare code
            acc_nxt[i] = (lane_ext[i] > acc_q[i]) ? lane_ext[i] : acc_q[i];
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc_q <= '0;
    end else if (beat_valid) begin
      acc_q <= acc_nxt;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= beat_valid & beat_last;  // One pulse per window
    end
  end

  // Result of the finished window, held until the next one
  always_ff @(posedge clk) begin
    if (beat_valid && beat_last) begin
      acc_data <= acc_nxt;
    end
  end

endmodule

/* rtl/pool_out_stage.sv */
module pool_out_stage import pool_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              acc_valid,
  input  acc_t [LANES-1:0]  acc_data,
  output logic              out_valid,
  output beat_t             out_data
);

  logic    [LANES-1:0]              lane_sign;
  logic    [LANES-1:0][ACC_W-SAMPLE_W:0] lane_hi;  // Bits above the 16-bit range
  logic    [LANES-1:0]              lane_fits;
  sample_t [LANES-1:0]              lane_sat;
  beat_t                            sat_data;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_sign[i] = acc_data[i][ACC_W-1];
      lane_hi[i]   = acc_data[i][ACC_W-1:SAMPLE_W-1];
      // In range when all upper bits match the sign
      lane_fits[i] = (&lane_hi[i]) | ~(|lane_hi[i]);
      if (lane_fits[i]) begin
        lane_sat[i] = acc_data[i][SAMPLE_W-1:0];
      end else begin
        lane_sat[i] = {lane_sign[i], {(SAMPLE_W-1){~lane_sign[i]}}};  // 32767 or -32768
      end
    end
  end

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      sat_data[i*SAMPLE_W +: SAMPLE_W] = lane_sat[i];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= acc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      out_data <= sat_data;
    end
  end

endmodule

/* rtl/pool_core.sv */
module pool_core import pool_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  beat_t      in_data,
  input  kdim_t      kernel_w,
  input  kdim_t      kernel_h,
  input  pool_type_e pool_type,
  output logic       out_valid,
  output beat_t      out_data
);

  // Window control to accumulator
  logic       beat_valid;
  beat_t      beat_data;
  logic       beat_first;
  logic       beat_last;
  pool_type_e beat_type;

  // Accumulator to output stage
  logic             acc_valid;
  acc_t [LANES-1:0] acc_data;

  pool_window_ctrl u_window_ctrl (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .kernel_w   (kernel_w),
    .kernel_h   (kernel_h),
    .pool_type  (pool_type),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_first (beat_first),
    .beat_last  (beat_last),
    .beat_type  (beat_type)
  );

  pool_accum_buf u_accum_buf (
    .clk        (clk),
    .rst        (rst),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_first (beat_first),
    .beat_last  (beat_last),
    .beat_type  (beat_type),
    .acc_valid  (acc_valid),
    .acc_data   (acc_data)
  );

  pool_out_stage u_out_stage (
    .clk       (clk),
    .rst       (rst),
    .acc_valid (acc_valid),
    .acc_data  (acc_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

/* sim/pool_core_tb.sv */
module pool_core_tb import pool_pkg::*; ();

  localparam int MAX_WIN = 32;
  localparam int SEED    = 32'hf0b1_a5e2;

  logic       clk;
  logic       rst;
  logic       in_valid;
  beat_t      in_data;
  kdim_t      kernel_w;
  kdim_t      kernel_h;
  pool_type_e pool_type;
  logic       out_valid;
  beat_t      out_data;

  // Window table
  int         num_win;
  kdim_t      tab_kw   [MAX_WIN];
  kdim_t      tab_kh   [MAX_WIN];
  pool_type_e tab_type [MAX_WIN];
  bit         tab_full [MAX_WIN];  // Full-scale samples
  int         tab_gap  [MAX_WIN];  // Idle cycles after each beat
  bit         tab_chg  [MAX_WIN];  // Config changes mid-window

  beat_t exp_data [$];
  int    exp_edge [$];
  int    exp_id   [$];

  int cycle;
  int errors;
  int pass_cnt;
  int fail_cnt;

  pool_core u_pool_core (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .kernel_w  (kernel_w),
    .kernel_h  (kernel_h),
    .pool_type (pool_type),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic add_window(input kdim_t kw, input kdim_t kh, input pool_type_e pt,
                            input bit full, input int gap, input bit chg);
    tab_kw[num_win]   = kw;
    tab_kh[num_win]   = kh;
    tab_type[num_win] = pt;
    tab_full[num_win] = full;
    tab_gap[num_win]  = gap;
    tab_chg[num_win]  = chg;
    num_win++;
  endtask

  task automatic build_table();
    num_win = 0;
    add_window(3'd0, 3'd0, POOL_MAX, 1'b1, 0, 1'b0);  // 1x1
    add_window(3'd0, 3'd0, POOL_MIN, 1'b1, 0, 1'b0);
    add_window(3'd2, 3'd2, POOL_MAX, 1'b0, 0, 1'b0);  // 3x3
    add_window(3'd2, 3'd2, POOL_MIN, 1'b1, 3, 1'b0);
    add_window(3'd7, 3'd7, POOL_MAX, 1'b1, 0, 1'b0);  // 8x8
    add_window(3'd7, 3'd7, POOL_MIN, 1'b0, 2, 1'b0);
    add_window(3'd2, 3'd2, POOL_SUM, 1'b0, 0, 1'b0);
    add_window(3'd7, 3'd7, POOL_SUM, 1'b0, 1, 1'b0);  // Exact sum
    add_window(3'd7, 3'd7, POOL_SUM, 1'b1, 0, 1'b0);  // Saturates
    add_window(3'd2, 3'd2, POOL_SUM, 1'b1, 4, 1'b1);
    add_window(3'd1, 3'd3, POOL_MAX, 1'b0, 0, 1'b1);
    add_window(3'd3, 3'd1, POOL_SUM, 1'b0, 2, 1'b0);
    add_window(3'd0, 3'd0, POOL_MIN, 1'b0, 5, 1'b0);
    add_window(3'd4, 3'd2, POOL_MIN, 1'b1, 0, 1'b0);
  endtask

  function automatic int window_beats(input int w);
    return (int'(tab_kw[w]) + 1) * (int'(tab_kh[w]) + 1);
  endfunction

  // Small samples mix signs; full-scale ones sit near the rails
  function automatic sample_t draw_sample(input bit full, input int lane);
    int   r;
    logic odd;
    odd = (lane % 2) == 1;
    if (full) begin
      r = int'($urandom);
      return {odd, ~odd, r[13:0]};  // Even lanes positive, odd negative
    end
    r = int'($urandom_range(400, 0)) - 200;
    return sample_t'(r);
  endfunction

  function automatic sample_t clamp_sum(input int v);
    if (v > 32767) begin
      return sample_t'(32767);
    end
    if (v < -32768) begin
      return sample_t'(-32768);
    end
    return sample_t'(v);
  endfunction

  task automatic drive_window(input int w);
    int      nbeats;
    int      acc [LANES];
    int      v;
    sample_t s;
    beat_t   data;
    beat_t   expect_beat;
    nbeats = window_beats(w);
    for (int b = 0; b < nbeats; b++) begin
      for (int i = 0; i < LANES; i++) begin
        s = draw_sample(tab_full[w], i);
        data[i*SAMPLE_W +: SAMPLE_W] = s;
        v = int'(s);
        if (b == 0) begin
          acc[i] = v;
        end else if (tab_type[w] == POOL_MIN) begin
          acc[i] = (v < acc[i]) ? v : acc[i];
        end else if (tab_type[w] == POOL_SUM) begin
          acc[i] = acc[i] + v;
        end else begin
          acc[i] = (v > acc[i]) ? v : acc[i];
        end
      end
      @(posedge clk);
      #1;
      in_valid = 1'b1;
      in_data  = data;
      if (b == 0) begin
        kernel_w  = tab_kw[w];
        kernel_h  = tab_kh[w];
        pool_type = tab_type[w];
      end else if (b == 1 && tab_chg[w] && w + 1 < num_win) begin
        kernel_w  = tab_kw[w+1];  // Next window's config arrives early
        kernel_h  = tab_kh[w+1];
        pool_type = tab_type[w+1];
      end
      if (b == nbeats - 1) begin
        for (int i = 0; i < LANES; i++) begin
          expect_beat[i*SAMPLE_W +: SAMPLE_W] = clamp_sum(acc[i]);
        end
        exp_data.push_back(expect_beat);
        exp_edge.push_back(cycle + 1 + 3);  // Sampled next edge, seen 3 edges on
        exp_id.push_back(w);
      end
      for (int g = 0; g < tab_gap[w]; g++) begin
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_data  = {$urandom, $urandom};  // Junk while idle
      end
    end
  endtask

  task automatic check_output();
    beat_t   want;
    int      want_edge;
    int      id;
    bit      bad;
    sample_t got_s;
    sample_t want_s;
    if (exp_data.size() == 0) begin
      errors++;
      $display("Error at time %0t: out_valid high with no window pending", $time);
    end else begin
      want      = exp_data.pop_front();
      want_edge = exp_edge.pop_front();
      id        = exp_id.pop_front();
      bad       = 1'b0;
      for (int i = 0; i < LANES; i++) begin
        got_s  = out_data[i*SAMPLE_W +: SAMPLE_W];
        want_s = want[i*SAMPLE_W +: SAMPLE_W];
        if (got_s != want_s) begin
          bad = 1'b1;
          $display("Mismatch at time %0t: window %0d lane %0d got %0d expected %0d",
                   $time, id, i, got_s, want_s);
        end
      end
      if (cycle != want_edge) begin
        bad = 1'b1;
        $display("Mismatch at time %0t: window %0d result at cycle %0d expected cycle %0d",
                 $time, id, cycle, want_edge);
      end
      if (bad) begin
        errors++;
        fail_cnt++;
        $display("Window %0d: failed", id);
      end else begin
        pass_cnt++;
        $display("Window %0d: ok, type %0d, %0d beats", id, tab_type[id], window_beats(id));
      end
    end
  endtask

  // Sees values from before the edge
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst) begin
      if (out_valid) begin
        errors++;
        $display("Error at time %0t: out_valid high during reset", $time);
      end
    end else if (out_valid) begin
      check_output();
    end
  end

  initial begin
    int limit_cycles;
    #1;
    limit_cycles = 0;
    for (int w = 0; w < num_win; w++) begin
      limit_cycles += window_beats(w) * (1 + tab_gap[w]);
    end
    limit_cycles = limit_cycles * 4 + 100;
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, %0d windows left unanswered",
             limit_cycles, exp_data.size());
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    cycle     = 0;
    errors    = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    kernel_w  = '0;
    kernel_h  = '0;
    pool_type = POOL_MAX;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int w = 0; w < num_win; w++) begin
      drive_window(w);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    while (exp_data.size() != 0) begin
      @(posedge clk);
    end
    repeat (6) @(posedge clk);  // Catch stray strobes
    $display("Windows passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, errors);
    if (errors == 0 && pass_cnt == num_win) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* pool_core.f */
rtl/pool_pkg.sv
rtl/pool_window_ctrl.sv
rtl/pool_accum_buf.sv
rtl/pool_out_stage.sv
rtl/pool_core.sv
sim/pool_core_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module pool_core_tb -Mdir obj_dir -f pool_core.f
	out=$$(./obj_dir/Vpool_core_tb); echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir
